//--- Bender.yml
package:
  name: tpl_pnmon

sources:
  - include_dirs:
      - common
    files:
      - common/pnmon_pkg.sv
      - common/pn_chan_if.sv
      - tpl_pnmon/link_sample_splitter.sv
      - tpl_pnmon/pn_sync_checker.sv
      - tpl_pnmon/channel_pnmon.sv
      - tpl_pnmon/pn_status_collector.sv
      - rtl/tpl_pnmon_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_clock_gen.sv
      - bench/pnmon_checker.sv
      - bench/tb_tpl_pnmon.sv

//--- bench/pnmon_checker.sv
// pnmon_checker: sync-rule model of every channel, output pipeline and compare of DUT ports

`timescale 1ns/1ps

`include "pnmon_macros.svh"

module pnmon_checker import pnmon_pkg::*; (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     link_valid,
  input  pn_seq_e                  pn_seq_sel,
  input  logic                     err_clear,
  // PN bits per channel as sent, oldest bit at the top
  input  logic [`PNMON_LINK_W-1:0] raw_words,
  input  logic [`PNMON_NUM_CH-1:0] pn_oos,
  input  logic [`PNMON_NUM_CH-1:0] pn_err,
  input  logic [`PNMON_NUM_CH-1:0] pn_err_sticky,
  input  logic                     all_locked,
  output int                       mismatch_count,
  output int                       check_count
);

  localparam int N    = `PNMON_NUM_CH;
  localparam int CH_W = `PNMON_CH_W;

  // per-channel sync model
  logic [CH_W-1:0] pred_m [N];
  logic [N-1:0]    oos_m;
  int              run_m [N];
  // stage 0 holds the result of the word sampled at this edge, stage 2 is on the ports
  logic [N-1:0]    oos_p [3];
  logic [N-1:0]    err_p [3];
  logic [N-1:0]    err_now;
  logic [N-1:0]    sticky_m;

  // next word of the selected PN sequence after the given word
  // b[n] = b[n-9] ^ b[n-5] for PN9, b[n-23] ^ b[n-18] otherwise
  function automatic logic [CH_W-1:0] extend_pn(input logic [CH_W-1:0] last,
                                                input pn_seq_e         sel);
    logic [CH_W+22:0] bits;
    bits = '0;
    bits[CH_W+22:CH_W] = last[22:0];
    for (int k = CH_W - 1; k >= 0; k--) begin
      if (sel == PN_SEQ_PN9) begin
        bits[k] = bits[k+9] ^ bits[k+5];
      end else begin
        bits[k] = bits[k+23] ^ bits[k+18];
      end
    end
    return bits[CH_W-1:0];
  endfunction

  // **************************************************************************
  // model of the sync rule
  // **************************************************************************

  always @(posedge clk or negedge arst_n) begin
    logic [CH_W-1:0] raw;
    logic            hit;
    if (!arst_n) begin
      oos_m    = '1;
      sticky_m = '0;
      for (int c = 0; c < N; c++) begin
        pred_m[c] = '0;
        run_m[c]  = 0;
      end
      for (int s = 0; s < 3; s++) begin
        oos_p[s] = '1;
        err_p[s] = '0;
      end
    end else begin
      // sticky takes the pulse that is on pn_err before this edge
      sticky_m = (sticky_m & ~{N{err_clear}}) | err_p[2];
      err_now  = '0;
      if (link_valid) begin
        for (int c = 0; c < N; c++) begin
          raw = raw_words[c*CH_W +: CH_W];
          hit = (raw == pred_m[c]);
          // out of sync the prediction restarts from the received word
          pred_m[c] = extend_pn(oos_m[c] ? raw : pred_m[c], pn_seq_sel);
          if (oos_m[c]) begin
            run_m[c] = hit ? run_m[c] + 1 : 0;
          end else begin
            run_m[c] = hit ? 0 : run_m[c] + 1;
          end
          if (run_m[c] == `PNMON_OOS_COUNT) begin
            // the word that flips the state gives no err
            oos_m[c] = ~oos_m[c];
            run_m[c] = 0;
          end else if (!oos_m[c] && !hit) begin
            err_now[c] = 1'b1;
          end
        end
      end
      for (int s = 2; s > 0; s--) begin
        oos_p[s] = oos_p[s-1];
        err_p[s] = err_p[s-1];
      end
      oos_p[0] = oos_m;
      err_p[0] = err_now;
    end
  end

  // **************************************************************************
  // compare, half a cycle after the DUT registers settle
  // **************************************************************************

  initial begin
    mismatch_count = 0;
    check_count    = 0;
  end

  task automatic compare_vec(input string name, input logic [N-1:0] got,
                             input logic [N-1:0] exp);
    check_count++;
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch at %0t ns: %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  always @(negedge clk) begin
    if (arst_n) begin
      compare_vec("pn_oos", pn_oos, oos_p[2]);
      compare_vec("pn_err", pn_err, err_p[2]);
      compare_vec("pn_err_sticky", pn_err_sticky, sticky_m);
      compare_vec("all_locked", {{(N-1){1'b0}}, all_locked},
                  {{(N-1){1'b0}}, ~|oos_p[2]});
    end
  end

endmodule

//--- bench/tb_clock_gen.sv
// tb_clock_gen: testbench clock of 8 ns period and active-low reset held for 10 cycles

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held low for the first 10 rising edges
  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

//--- bench/tb_tpl_pnmon.sv
// tb_tpl_pnmon: testbench top with PN generator, random stimulus, watchdog and test sequence

`timescale 1ns/1ps

`include "pnmon_macros.svh"

module tb_tpl_pnmon import pnmon_pkg::*;;

  localparam int N      = `PNMON_NUM_CH;
  localparam int RES    = `PNMON_CONV_RES;
  localparam int DPW    = `PNMON_DPW;
  localparam int CH_W   = `PNMON_CH_W;
  localparam int LINK_W = `PNMON_LINK_W;

  // test lengths in cycles, words times the longest word plus gap
  localparam int TEST_CYCLES = 60*4 + 80*4 + 60*4 + 64*3 + 100*21 + 60*3;
  // reset, flushes and relock margin
  localparam int MARGIN_CYCLES = 400;
  localparam longint WATCHDOG_NS = longint'(TEST_CYCLES + MARGIN_CYCLES) * 8 * 2;

  logic              clk;
  logic              arst_n;
  logic [LINK_W-1:0] link_data;
  logic              link_valid;
  pn_seq_e           pn_seq_sel;
  logic              err_clear;
  logic [N-1:0]      pn_oos;
  logic [N-1:0]      pn_err;
  logic [N-1:0]      pn_err_sticky;
  logic              all_locked;
  logic [LINK_W-1:0] raw_words;
  int                mismatch_count;
  int                check_count;

  // generator history per channel, newest bit in bit 0
  logic [22:0]       pn_state [N];
  int                injected;
  int                tests_failed;

  tb_clock_gen u_clk (
    .clk    (clk),
    .arst_n (arst_n)
  );

  tpl_pnmon_top u_dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .link_data     (link_data),
    .link_valid    (link_valid),
    .pn_seq_sel    (pn_seq_sel),
    .err_clear     (err_clear),
    .pn_oos        (pn_oos),
    .pn_err        (pn_err),
    .pn_err_sticky (pn_err_sticky),
    .all_locked    (all_locked)
  );

  pnmon_checker u_chk (
    .clk            (clk),
    .arst_n         (arst_n),
    .link_valid     (link_valid),
    .pn_seq_sel     (pn_seq_sel),
    .err_clear      (err_clear),
    .raw_words      (raw_words),
    .pn_oos         (pn_oos),
    .pn_err         (pn_err),
    .pn_err_sticky  (pn_err_sticky),
    .all_locked     (all_locked),
    .mismatch_count (mismatch_count),
    .check_count    (check_count)
  );

  // **************************************************************************
  // PN generator and link packing
  // **************************************************************************

  // one channel word, first generated bit at the top
  task automatic next_raw(input int c, output logic [CH_W-1:0] raw);
    logic nb;
    raw = '0;
    for (int k = 0; k < CH_W; k++) begin
      if (pn_seq_sel == PN_SEQ_PN9) begin
        nb = pn_state[c][8] ^ pn_state[c][4];
      end else begin
        nb = pn_state[c][22] ^ pn_state[c][17];
      end
      pn_state[c] = {pn_state[c][21:0], nb};
      raw = {raw[CH_W-2:0], nb};
    end
  endtask

  // sign flip to offset binary, sample 0 in the low slot, octets msb first
  function automatic logic [CH_W-1:0] pack_channel(input logic [CH_W-1:0] raw);
    logic [RES-1:0]  smp;
    logic [CH_W-1:0] w;
    w = '0;
    for (int i = 0; i < DPW; i++) begin
      smp = raw[(DPW-1-i)*RES +: RES];
      smp[RES-1] = ~smp[RES-1];
      for (int o = 0; o < RES/8; o++) begin
        w[i*RES + (RES/8-1-o)*8 +: 8] = smp[o*8 +: 8];
      end
    end
    return w;
  endfunction

  // **************************************************************************
  // stimulus
  // **************************************************************************

  // flip_mask puts one bit error on a channel, junk_mask replaces its word
  task automatic drive_word(input logic [N-1:0] flip_mask, input logic [N-1:0] junk_mask);
    logic [CH_W-1:0]   raw;
    logic [LINK_W-1:0] ld;
    logic [LINK_W-1:0] rw;
    int                pos;
    for (int c = 0; c < N; c++) begin
      next_raw(c, raw);
      if (junk_mask[c]) begin
        raw = CH_W'($urandom);
      end
      if (flip_mask[c]) begin
        pos = $urandom % CH_W;
        raw[pos] = ~raw[pos];
        injected++;
      end
      ld[c*CH_W +: CH_W] = pack_channel(raw);
      rw[c*CH_W +: CH_W] = raw;
    end
    @(posedge clk);
    link_data  <= ld;
    link_valid <= 1'b1;
    raw_words  <= rw;
  endtask

  // gap cycles, data toggles to show it is ignored
  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      link_valid <= 1'b0;
      link_data  <= ~link_data;
    end
  endtask

  task automatic run_words(input int n, input int max_gap, input int flip_pct,
                           input logic [N-1:0] junk_mask);
    logic [N-1:0] flip;
    for (int i = 0; i < n; i++) begin
      flip = '0;
      if (($urandom % 100) < flip_pct) begin
        flip[$urandom % N] = 1'b1;
      end
      drive_word(flip, junk_mask);
      idle($urandom % (max_gap + 1));
    end
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    err_clear <= 1'b1;
    @(posedge clk);
    err_clear <= 1'b0;
  endtask

  task automatic report_test(input int num, input string name, input int start_mm,
                             input int extra_fail);
    int delta;
    delta = mismatch_count - start_mm;
    if (delta != 0 || extra_fail != 0) begin
      tests_failed++;
      $display("test %0d %s: failed, %0d mismatches", num, name, delta);
    end else begin
      $display("test %0d %s: ok", num, name);
    end
  endtask

  // **************************************************************************
  // watchdog
  // **************************************************************************

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  // **************************************************************************
  // test sequence
  // **************************************************************************

  initial begin
    int start_mm;
    int bad;
    int k;
    void'($urandom(32'h5e866268));
    link_data    = '0;
    link_valid   = 1'b0;
    pn_seq_sel   = PN_SEQ_PN9;
    err_clear    = 1'b0;
    raw_words    = '0;
    injected     = 0;
    tests_failed = 0;
    // random nonzero start, bit 0 keeps the PN9 part nonzero too
    for (int c = 0; c < N; c++) begin
      pn_state[c]    = 23'($urandom);
      pn_state[c][0] = 1'b1;
    end
    @(posedge arst_n);
    idle(4);

    // 1: clean PN9 lock
    start_mm = mismatch_count;
    run_words(60, 3, 0, '0);
    idle(8);
    bad = (all_locked !== 1'b1);
    if (bad) $display("test 1: channels did not lock on PN9");
    report_test(1, "pn9_lock", start_mm, bad);

    // 2: switch to PN23 in a gap, lose lock and relock
    start_mm = mismatch_count;
    @(posedge clk);
    pn_seq_sel <= PN_SEQ_PN23;
    idle(4);
    run_words(80, 3, 0, '0);
    idle(8);
    pulse_clear();
    idle(4);
    bad = (all_locked !== 1'b1) || (pn_err_sticky !== '0);
    if (bad) $display("test 2: no relock on PN23 or sticky bits not cleared");
    report_test(2, "pn23_switch", start_mm, bad);

    // 3: isolated bit errors
    start_mm = mismatch_count;
    run_words(60, 3, 12, '0);
    idle(8);
    bad = (all_locked !== 1'b1) || (injected != 0 && pn_err_sticky === '0);
    if (bad) $display("test 3: lock lost or no sticky bit after injected errors");
    report_test(3, "bit_errors", start_mm, bad);

    // 4: random burst on one channel
    start_mm = mismatch_count;
    k = $urandom % N;
    run_words(24, 2, 0, N'(1) << k);
    run_words(40, 2, 0, '0);
    idle(8);
    bad = (all_locked !== 1'b1);
    if (bad) $display("test 4: channel %0d did not relock after the burst", k);
    report_test(4, "loss_of_sync", start_mm, bad);

    // 5: drop lock everywhere, relock across long valid gaps
    start_mm = mismatch_count;
    run_words(20, 1, 0, '1);
    run_words(80, 20, 0, '0);
    idle(8);
    bad = (all_locked !== 1'b1);
    if (bad) $display("test 5: no relock across long valid gaps");
    report_test(5, "valid_gaps", start_mm, bad);

    // 6: clear, then an error landing on the sticky register with a clear
    start_mm = mismatch_count;
    pulse_clear();
    idle(4);
    k = $urandom % N;
    drive_word(N'(1) << k, '0);
    idle(2);
    @(posedge clk);
    err_clear <= 1'b1;
    @(posedge clk);
    err_clear <= 1'b0;
    idle(6);
    bad = (pn_err_sticky !== (N'(1) << k));
    if (bad) $display("test 6: sticky bit of channel %0d lost to a same-cycle clear", k);
    run_words(20, 2, 0, '0);
    idle(8);
    report_test(6, "sticky_clear", start_mm, bad);

    $display("summary: %0d tests failed, %0d checks, %0d mismatches, %0d injected errors",
             tests_failed, check_count, mismatch_count, injected);
    if (tests_failed == 0 && mismatch_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- common/pn_chan_if.sv
// pn_chan_if: per-channel bundle of samples, valid, out-of-sync and error with modports

`timescale 1ns/1ps

`include "pnmon_macros.svh"

interface pn_chan_if;

  // channel word, sample 0 in the low slot, octets already in sample order
  logic [`PNMON_CH_W-1:0] samples;
  // qualifies samples, a level and not a handshake
  logic                   valid;
  // channel out of sync
  logic                   oos;
  // one pulse per mismatching word while in sync
  logic                   err;

  // splitter side
  modport src (
    output samples,
    output valid
  );

  // channel monitor side
  modport mon (
    input  samples,
    input  valid,
    output oos,
    output err
  );

  // status collector side
  modport sink (
    input oos,
    input err
  );

endinterface

//--- common/pnmon_macros.svh
// pnmon_macros: channel geometry and sync thresholds of the test-pattern monitor

`ifndef PNMON_MACROS_SVH
`define PNMON_MACROS_SVH

// converter channels packed into one link word
`define PNMON_NUM_CH 4

// bits per converter sample, must be a multiple of 8
`define PNMON_CONV_RES 16

// samples per channel per clock
`define PNMON_DPW 2

// bits per channel per clock
`define PNMON_CH_W (`PNMON_CONV_RES * `PNMON_DPW)

// whole deframed link word
`define PNMON_LINK_W (`PNMON_NUM_CH * `PNMON_CH_W)

// consecutive valid words needed to enter or leave sync
`define PNMON_OOS_COUNT 16

// hysteresis counter width, holds up to OOS_COUNT - 1
`define PNMON_CNT_W 5

`endif

//--- common/pnmon_pkg.sv
// pnmon_pkg: PN sequence select and sync state enums for the test-pattern monitor

package pnmon_pkg;

  // **************************************************************************
  // pattern select
  // **************************************************************************

  // 4-bit select as seen on the control side
  // only PN9 has its own code, every other code falls back to PN23
  typedef enum logic [3:0] {
    PN_SEQ_PN9  = 4'd0,
    PN_SEQ_PN23 = 4'd1
  } pn_seq_e;

  // **************************************************************************
  // checker sync state
  // **************************************************************************

  // encoded so that the state bit equals the oos flag
  typedef enum logic {
    ST_LOCKED = 1'b0,
    ST_OOS    = 1'b1
  } sync_state_e;

endpackage

//--- rtl/tpl_pnmon_top.sv
// tpl_pnmon_top: splitter, per-channel PN monitors and status collector with plain ports

`timescale 1ns/1ps

`include "pnmon_macros.svh"

module tpl_pnmon_top import pnmon_pkg::*; (
  input  logic                     clk,
  input  logic                     arst_n,
  // deframed link word
  input  logic [`PNMON_LINK_W-1:0] link_data,
  input  logic                     link_valid,
  // PN9 or PN23, shared by all channels
  input  pn_seq_e                  pn_seq_sel,
  // status
  input  logic                     err_clear,
  output logic [`PNMON_NUM_CH-1:0] pn_oos,
  output logic [`PNMON_NUM_CH-1:0] pn_err,
  output logic [`PNMON_NUM_CH-1:0] pn_err_sticky,
  output logic                     all_locked
);

  // one bundle per converter channel
  pn_chan_if chan [`PNMON_NUM_CH] ();

  link_sample_splitter u_splitter (
    .clk        (clk),
    .arst_n     (arst_n),
    .link_data  (link_data),
    .link_valid (link_valid),
    .ch         (chan)
  );

  // **************************************************************************
  // channel monitors
  // **************************************************************************

  for (genvar c = 0; c < `PNMON_NUM_CH; c++) begin : g_chan
    channel_pnmon #(
      .TWOS_COMPLEMENT (1)
    ) u_pnmon (
      .clk     (clk),
      .arst_n  (arst_n),
      .seq_sel (pn_seq_sel),
      .ch      (chan[c])
    );
  end

  pn_status_collector u_status (
    .clk           (clk),
    .arst_n        (arst_n),
    .ch            (chan),
    .err_clear     (err_clear),
    .pn_oos        (pn_oos),
    .pn_err        (pn_err),
    .pn_err_sticky (pn_err_sticky),
    .all_locked    (all_locked)
  );

endmodule

//--- tpl_pnmon/channel_pnmon.sv
// channel_pnmon: PN9/PN23 predictor with self-seeding, sign restore and sample swizzle

`timescale 1ns/1ps

`include "pnmon_macros.svh"

module channel_pnmon import pnmon_pkg::*; #(
  parameter int TWOS_COMPLEMENT = 1
) (
  input  logic    clk,
  input  logic    arst_n,
  input  pn_seq_e seq_sel,
  pn_chan_if.mon  ch
);

  localparam int RES  = `PNMON_CONV_RES;
  localparam int DPW  = `PNMON_DPW;
  localparam int CH_W = `PNMON_CH_W;
  // predictor holds at least the 23 bits that PN23 looks back over
  localparam int PN_W = (CH_W > 23) ? CH_W : 23;

  localparam logic TC = (TWOS_COMPLEMENT != 0) ? 1'b1 : 1'b0;

  logic [CH_W-1:0]      raw_s;
  logic [CH_W-1:0]      pn_layout_s;
  logic [PN_W-1:0]      seed_s;
  logic [PN_W-1:0]      pn_base_s;
  logic [CH_W-1:0]      pn_nxt_s;
  logic [PN_W+CH_W-1:0] pn_full_s;
  logic [PN_W-1:0]      pn_q;
  logic                 oos_s;

  // one word of PN bits, msb is the oldest bit
  // state bit 0 is the newest bit of the seed
  function automatic logic [CH_W-1:0] pn_next(input logic [PN_W-1:0] seed,
                                             input pn_seq_e         sel);
    logic [22:0]     sr;
    logic            nb;
    logic [CH_W-1:0] res;
    sr  = seed[22:0];
    res = '0;
    for (int j = CH_W - 1; j >= 0; j--) begin
      // x^9 + x^5 + 1
      if (sel == PN_SEQ_PN9) begin
        nb = sr[8] ^ sr[4];
      // x^23 + x^18 + 1, also for unknown codes
      end else begin
        nb = sr[22] ^ sr[17];
      end
      res[j] = nb;
      sr     = {sr[21:0], nb};
    end
    return res;
  endfunction

  // **************************************************************************
  // sample swizzle
  // **************************************************************************

  // sample 0 is the oldest and goes to the top of the PN word
  // sign bit flipped back out of offset binary when configured
  for (genvar i = 0; i < DPW; i++) begin : g_swizzle
    localparam int SRC_LSB = i * RES;
    localparam int DST_LSB = (DPW - 1 - i) * RES;

    assign raw_s[DST_LSB+RES-1]         = TC ^ ch.samples[SRC_LSB+RES-1];
    assign raw_s[DST_LSB +: RES-1]      = ch.samples[SRC_LSB +: RES-1];
    // same mapping run backwards for the prediction
    assign pn_layout_s[SRC_LSB+RES-1]   = TC ^ pn_q[DST_LSB+RES-1];
    assign pn_layout_s[SRC_LSB +: RES-1] = pn_q[DST_LSB +: RES-1];
  end

  // **************************************************************************
  // seed
  // **************************************************************************

  if (PN_W > CH_W) begin : g_seed_hist
    // narrow words, older raw bits kept to fill the PN23 state
    logic [PN_W-CH_W-1:0] hist_q;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        hist_q <= '0;
      end else if (ch.valid) begin
        hist_q <= seed_s[PN_W-CH_W-1:0];
      end
    end

    assign seed_s = {hist_q, raw_s};
  end else begin : g_seed_word
    assign seed_s = raw_s;
  end

  // **************************************************************************
  // predictor
  // **************************************************************************

  // out of sync, restart from what was just received
  assign pn_base_s = oos_s ? seed_s : pn_q;
  assign pn_nxt_s  = pn_next(pn_base_s, seq_sel);
  // newest word in the low bits, older bits shift up
  assign pn_full_s = {pn_base_s, pn_nxt_s};

  // steps only on valid words, holds across gaps
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pn_q <= '0;
    end else if (ch.valid) begin
      pn_q <= pn_full_s[PN_W-1:0];
    end
  end

  // compare in the received layout
  pn_sync_checker u_checker (
    .clk     (clk),
    .arst_n  (arst_n),
    .valid   (ch.valid),
    .data_rx (ch.samples),
    .data_pn (pn_layout_s),
    .oos     (oos_s),
    .err     (ch.err)
  );

  assign ch.oos = oos_s;

endmodule

//--- tpl_pnmon/link_sample_splitter.sv
// link_sample_splitter: link word register, per-sample octet reorder and channel slicing

`timescale 1ns/1ps

`include "pnmon_macros.svh"

module link_sample_splitter (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [`PNMON_LINK_W-1:0] link_data,
  input  logic                     link_valid,
  pn_chan_if.src                   ch [`PNMON_NUM_CH]
);

  localparam int RES     = `PNMON_CONV_RES;
  localparam int OCTS    = RES / 8;
  localparam int NUM_SMP = `PNMON_LINK_W / RES;
  localparam int CH_W    = `PNMON_CH_W;

  logic [`PNMON_LINK_W-1:0] swapped_s;
  logic [`PNMON_LINK_W-1:0] data_q;
  logic                     valid_q;

  // **************************************************************************
  // octet reorder
  // **************************************************************************

  // octets arrive msb first within every sample
  // flip them so the sample reads as a normal little-endian slice
  always_comb begin
    swapped_s = '0;
    for (int s = 0; s < NUM_SMP; s++) begin
      for (int o = 0; o < OCTS; o++) begin
        swapped_s[s*RES + o*8 +: 8] = link_data[s*RES + (OCTS-1-o)*8 +: 8];
      end
    end
  end

  // **************************************************************************
  // link register
  // **************************************************************************

  // word payload only loads on valid words
  always_ff @(posedge clk) begin
    if (link_valid) begin
      data_q <= swapped_s;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= link_valid;
    end
  end

  // one slice per channel, valid shared by all
  for (genvar c = 0; c < `PNMON_NUM_CH; c++) begin : g_slice
    assign ch[c].samples = data_q[c*CH_W +: CH_W];
    assign ch[c].valid   = valid_q;
  end

  // an unknown valid would poison every channel counter downstream
  a_valid_known : assert property (
    @(posedge clk) disable iff (!arst_n) !$isunknown(link_valid)
  );

endmodule

//--- tpl_pnmon/pn_status_collector.sv
// pn_status_collector: per-channel oos and err registers, sticky errors and all-locked level

`timescale 1ns/1ps

`include "pnmon_macros.svh"

module pn_status_collector (
  input  logic                     clk,
  input  logic                     arst_n,
  pn_chan_if.sink                  ch [`PNMON_NUM_CH],
  input  logic                     err_clear,
  output logic [`PNMON_NUM_CH-1:0] pn_oos,
  output logic [`PNMON_NUM_CH-1:0] pn_err,
  output logic [`PNMON_NUM_CH-1:0] pn_err_sticky,
  output logic                     all_locked
);

  localparam int N = `PNMON_NUM_CH;

  logic [N-1:0] oos_s;
  logic [N-1:0] err_s;

  // gather the channel flags into vectors
  for (genvar c = 0; c < N; c++) begin : g_gather
    assign oos_s[c] = ch[c].oos;
    assign err_s[c] = ch[c].err;
  end

  // **************************************************************************
  // status registers
  // **************************************************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pn_oos     <= '1;
      pn_err     <= '0;
      all_locked <= 1'b0;
    end else begin
      pn_oos     <= oos_s;
      pn_err     <= err_s;
      all_locked <= ~|oos_s;
    end
  end

  // sticky bits take the registered pulse, one cycle after pn_err
  // set beats clear when both land together
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pn_err_sticky <= '0;
    end else begin
      pn_err_sticky <= (pn_err_sticky & ~{N{err_clear}}) | pn_err;
    end
  end

endmodule

//--- tpl_pnmon/pn_sync_checker.sv
// pn_sync_checker: received vs predicted compare, out-of-sync hysteresis FSM and error pulse

`timescale 1ns/1ps

`include "pnmon_macros.svh"

module pn_sync_checker import pnmon_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   valid,
  input  logic [`PNMON_CH_W-1:0] data_rx,
  input  logic [`PNMON_CH_W-1:0] data_pn,
  output logic                   oos,
  output logic                   err
);

  // last count before the state flips
  localparam logic [`PNMON_CNT_W-1:0] CNT_LAST = `PNMON_CNT_W'(`PNMON_OOS_COUNT - 1);

  sync_state_e              state_q;
  logic [`PNMON_CNT_W-1:0]  cnt_q;
  logic                     match_s;
  logic                     cnt_last_s;

  assign match_s    = (data_rx == data_pn);
  assign cnt_last_s = (cnt_q == CNT_LAST);

  // **************************************************************************
  // hysteresis FSM
  // **************************************************************************

  // cnt_q counts consecutive results against the current state
  // ST_OOS counts matches, ST_LOCKED counts mismatches
  // compare result is registered straight into state, count and err
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ST_OOS;
      cnt_q   <= '0;
      err     <= 1'b0;
    end else begin
      // err is a single cycle pulse
      err <= 1'b0;
      if (valid) begin
        unique case (state_q)
          ST_OOS: begin
            if (!match_s) begin
              cnt_q <= '0;
            end else if (cnt_last_s) begin
              state_q <= ST_LOCKED;
              cnt_q   <= '0;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
          ST_LOCKED: begin
            if (match_s) begin
              // one good word breaks the run
              cnt_q <= '0;
            end else if (cnt_last_s) begin
              // word that drops sync reports via oos, not err
              state_q <= ST_OOS;
              cnt_q   <= '0;
            end else begin
              cnt_q <= cnt_q + 1'b1;
              err   <= 1'b1;
            end
          end
        endcase
      end
    end
  end

  // state encoding doubles as the flag
  assign oos = (state_q == ST_OOS);

  // **************************************************************************
  // checks
  // **************************************************************************

  a_err_in_sync : assert property (
    @(posedge clk) disable iff (!arst_n) err |-> !oos
  );

  a_cnt_bound : assert property (
    @(posedge clk) disable iff (!arst_n) cnt_q <= `PNMON_OOS_COUNT
  );

endmodule

//--- vlog.f
+incdir+common
common/pnmon_pkg.sv
common/pn_chan_if.sv
tpl_pnmon/link_sample_splitter.sv
tpl_pnmon/pn_sync_checker.sv
tpl_pnmon/channel_pnmon.sv
tpl_pnmon/pn_status_collector.sv
rtl/tpl_pnmon_top.sv
bench/tb_clock_gen.sv
bench/pnmon_checker.sv
bench/tb_tpl_pnmon.sv
